//--- hdl/parity_mem_config.svh
`ifndef PARITY_MEM_CONFIG_SVH
`define PARITY_MEM_CONFIG_SVH

// byte address width. [2:0] picks the lane, the rest picks the word.
`define PM_ADDR_W 10

// error counter width, saturates at all ones.
`define PM_CNT_W 8

`endif

//--- hdl/parity_mem_pkg.sv
package parity_mem_pkg;

`include "parity_mem_config.svh"

    // command encoding on cmd_op.
    typedef enum logic [1:0] {
        op_nop    = 2'd0,
        op_write  = 2'd1,
        op_read   = 2'd2,
        op_inject = 2'd3
    } pm_op_e;

    // byte address, lane in the low three bits.
    typedef logic [`PM_ADDR_W-1:0] byte_addr_t;

    // word address, byte address without the lane bits.
    typedef logic [`PM_ADDR_W-4:0] word_addr_t;

    // user data, the eighth stored bit is parity.
    typedef logic [6:0] data_t;

    typedef logic [`PM_CNT_W-1:0] cnt_t;

endpackage

//--- hdl/mem_if.sv
`timescale 1ns/1ns

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte side, access_ctrl to lane_codec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface byte_if;
    import parity_mem_pkg::*;

    byte_addr_t addr;
    logic       wr;
    logic       rd;
    logic       inject;
    data_t      wdata;
    data_t      rdata;
    logic       rerr;
    logic       rvalid;

    modport ctrl (output addr, wr, rd, inject, wdata, input rdata, rerr, rvalid);
    modport codec (input addr, wr, rd, inject, wdata, output rdata, rerr, rvalid);
endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word side, lane_codec to word_array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface word_if;
    import parity_mem_pkg::*;

    word_addr_t  waddr;
    logic [7:0]  lane_we;  // one-hot.
    logic [63:0] wword;    // encoded byte in every lane.
    logic        re;
    logic [63:0] rword;

    modport codec (output waddr, lane_we, wword, re, input rword);
    modport array (input waddr, lane_we, wword, re, output rword);
endinterface

//--- hdl/access_ctrl.sv
`timescale 1ns/1ns

module access_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  parity_mem_pkg::pm_op_e     cmd_op,
    input  parity_mem_pkg::byte_addr_t cmd_addr,
    input  parity_mem_pkg::data_t      cmd_data,
    byte_if.ctrl                      bus,
    output logic                      rsp_valid,
    output parity_mem_pkg::data_t      rsp_data,
    output logic                      rsp_err,
    output parity_mem_pkg::byte_addr_t rsp_addr
);
    import parity_mem_pkg::*;

    logic wr_d;
    logic rd_d;
    logic inject_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1, decode and register the command
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_d     = 1'b0;
        rd_d     = 1'b0;
        inject_d = 1'b0;
        if (cmd_valid) begin
            case (cmd_op)
                op_write:  wr_d     = 1'b1;
                op_read:   rd_d     = 1'b1;
                op_inject: inject_d = 1'b1;
                default:   ;  // nop.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.wr     <= 1'b0;
            bus.rd     <= 1'b0;
            bus.inject <= 1'b0;
        end else begin
            bus.wr     <= wr_d;
            bus.rd     <= rd_d;
            bus.inject <= inject_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            bus.addr  <= cmd_addr;
            bus.wdata <= cmd_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2, read address rides along with the array read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (bus.rd) begin
            rsp_addr <= bus.addr;
        end
    end

    assign rsp_valid = bus.rvalid;
    assign rsp_data  = bus.rdata;
    assign rsp_err   = bus.rerr;  // already qualified by rvalid.

endmodule

//--- hdl/lane_codec.sv
`timescale 1ns/1ns

module lane_codec (
    input  logic   clk,
    input  logic   rst_n,
    byte_if.codec bus,
    word_if.codec mem
);
    import parity_mem_pkg::*;

    logic       parity;
    logic [7:0] enc_byte;
    logic       rd_q;
    logic [2:0] lane_q;
    logic [7:0] stored;
    data_t      stored_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign parity   = (^bus.wdata) ^ bus.inject;  // even parity, flipped on inject.
    assign enc_byte = {parity, bus.wdata};

    assign mem.waddr   = word_addr_t'(bus.addr >> 3);
    assign mem.wword   = {8{enc_byte}};
    assign mem.lane_we = (bus.wr || bus.inject) ? (8'b1 << bus.addr[2:0]) : 8'b0;
    assign mem.re      = bus.rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path, lane select follows the registered array word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= bus.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd) begin
            lane_q <= bus.addr[2:0];
        end
    end

    assign stored      = mem.rword[lane_q*8 +: 8];
    assign stored_data = stored[6:0];

    assign bus.rvalid = rd_q;
    assign bus.rdata  = stored_data;
    assign bus.rerr   = rd_q & (^stored);  // odd count of ones means bad parity.

endmodule

//--- hdl/word_array.sv
`timescale 1ns/1ns

`include "parity_mem_config.svh"

module word_array (
    input  logic   clk,
    word_if.array mem
);

    localparam int num_words = 1 << (`PM_ADDR_W - 3);

    logic [63:0] store [num_words];

    // per-lane write.
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 8; lane++) begin
            if (mem.lane_we[lane]) begin
                store[mem.waddr][lane*8 +: 8] <= mem.wword[lane*8 +: 8];
            end
        end
    end

    // whole word read, held between reads.
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.rword <= store[mem.waddr];
        end
    end

endmodule

//--- hdl/error_log.sv
`timescale 1ns/1ns

module error_log (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rsp_valid,
    input  logic                      rsp_err,
    input  parity_mem_pkg::byte_addr_t rsp_addr,
    input  logic                      clear_log,
    output parity_mem_pkg::cnt_t       err_count,
    output parity_mem_pkg::byte_addr_t first_err_addr,
    output logic                      first_err_valid
);
    import parity_mem_pkg::*;

    localparam cnt_t cnt_max = '1;

    logic hit;

    assign hit = rsp_valid & rsp_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_count       <= '0;
            first_err_valid <= 1'b0;
        end else if (clear_log) begin
            err_count       <= '0;  // clear wins over a same cycle error.
            first_err_valid <= 1'b0;
        end else if (hit) begin
            if (err_count != cnt_max) begin
                err_count <= err_count + 1'b1;
            end
            first_err_valid <= 1'b1;
        end
    end

    // capture only while nothing is held.
    always_ff @(posedge clk) begin
        if (hit && !first_err_valid && !clear_log) begin
            first_err_addr <= rsp_addr;
        end
    end

endmodule

//--- hdl/parity_mem_top.sv
`timescale 1ns/1ns

module parity_mem_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  parity_mem_pkg::pm_op_e     cmd_op,
    input  parity_mem_pkg::byte_addr_t cmd_addr,
    input  parity_mem_pkg::data_t      cmd_data,
    input  logic                      clear_log,
    output logic                      rsp_valid,
    output parity_mem_pkg::data_t      rsp_data,
    output logic                      rsp_err,
    output parity_mem_pkg::cnt_t       err_count,
    output parity_mem_pkg::byte_addr_t first_err_addr,
    output logic                      first_err_valid
);
    import parity_mem_pkg::*;

    byte_addr_t rsp_addr;  // address of the response in flight.

    byte_if byte_bus ();
    word_if word_bus ();

    access_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .bus       (byte_bus.ctrl),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err),
        .rsp_addr  (rsp_addr)
    );

    lane_codec u_codec (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (byte_bus.codec),
        .mem   (word_bus.codec)
    );

    word_array u_array (
        .clk (clk),
        .mem (word_bus.array)
    );

    error_log u_log (
        .clk             (clk),
        .rst_n           (rst_n),
        .rsp_valid       (rsp_valid),
        .rsp_err         (rsp_err),
        .rsp_addr        (rsp_addr),
        .clear_log       (clear_log),
        .err_count       (err_count),
        .first_err_addr  (first_err_addr),
        .first_err_valid (first_err_valid)
    );

endmodule

//--- tb/parity_mem_chk.sv
`timescale 1ns/1ns

module parity_mem_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       cmd_valid,
    input parity_mem_pkg::pm_op_e     cmd_op,
    input logic                       clear_log,
    input logic                       rsp_valid,
    input parity_mem_pkg::cnt_t       err_count,
    input parity_mem_pkg::byte_addr_t first_err_addr,
    input logic                       first_err_valid
);
    import parity_mem_pkg::*;

    logic rd_cmd;

    assign rd_cmd = cmd_valid && (cmd_op == op_read);

    rsp_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
        else $error("rsp_valid high just after reset");

    // both directions, a read always answers and nothing else does.
    rsp_two_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(rd_cmd, 2))
        else $error("rsp_valid not two cycles after a read command");

    count_no_decrease: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(clear_log) |-> err_count >= $past(err_count))
        else $error("err_count went down without clear_log");

    first_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        first_err_valid && $past(first_err_valid) |-> $stable(first_err_addr))
        else $error("first_err_addr changed while first_err_valid was high");

endmodule

bind parity_mem_top parity_mem_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd_op          (cmd_op),
    .clear_log       (clear_log),
    .rsp_valid       (rsp_valid),
    .err_count       (err_count),
    .first_err_addr  (first_err_addr),
    .first_err_valid (first_err_valid)
);

//--- tb/parity_mem_tb.sv
`timescale 1ns/1ns

module parity_mem_tb;
    import parity_mem_pkg::*;

    localparam int reset_cycles = 16;
    localparam int n_saturate   = 260;
    localparam int n_directed   = 4 * 27 + 1 + n_saturate;
    localparam int n_random     = 2000;
    localparam int total_cycles = reset_cycles + n_directed + n_random + 8;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    pm_op_e      cmd_op;
    byte_addr_t  cmd_addr;
    data_t       cmd_data;
    logic        clear_log;
    logic        rsp_valid;
    data_t       rsp_data;
    logic        rsp_err;
    cnt_t        err_count;
    byte_addr_t  first_err_addr;
    logic        first_err_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [7:0]  model_mem [byte_addr_t];  // encoded byte with parity in bit 7.
    logic        exp_valid_q [$];          // one entry per cycle.
    data_t       exp_data_q [$];
    logic        exp_err_q [$];
    byte_addr_t  exp_addr_q [$];
    cnt_t        model_count;
    logic        model_first_valid;
    byte_addr_t  model_first_addr;
    logic [31:0] rng;

    parity_mem_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_addr        (cmd_addr),
        .cmd_data        (cmd_data),
        .clear_log       (clear_log),
        .rsp_valid       (rsp_valid),
        .rsp_data        (rsp_data),
        .rsp_err         (rsp_err),
        .err_count       (err_count),
        .first_err_addr  (first_err_addr),
        .first_err_valid (first_err_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(total_cycles * 4 + 400);
        $display("timeout: the run did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_outputs();
        logic       v;
        data_t      d;
        logic       e;
        byte_addr_t a;
        // log state already holds last cycle's response and clear.
        compare_values("err_count", 32'(err_count), 32'(model_count));
        compare_values("first_err_valid", 32'(first_err_valid), 32'(model_first_valid));
        if (model_first_valid) begin
            compare_values("first_err_addr", 32'(first_err_addr), 32'(model_first_addr));
        end
        if (exp_valid_q.size() == 2) begin
            v = exp_valid_q.pop_front();
            d = exp_data_q.pop_front();
            e = exp_err_q.pop_front();
            a = exp_addr_q.pop_front();
            compare_values("rsp_valid", 32'(rsp_valid), 32'(v));
            if (v) begin
                compare_values("rsp_data", 32'(rsp_data), 32'(d));
                compare_values("rsp_err", 32'(rsp_err), 32'(e));
                if (e) begin
                    if (model_count != '1) begin
                        model_count++;
                    end
                    if (!model_first_valid) begin
                        model_first_valid = 1'b1;
                        model_first_addr  = a;
                    end
                end
            end
        end else begin
            compare_values("rsp_valid", 32'(rsp_valid), 32'd0);
        end
    endtask

    // check what is visible this cycle, then drive the next command.
    task automatic issue_cmd(input logic valid, input pm_op_e op, input byte_addr_t addr,
                             input data_t data, input logic clr);
        logic rd;
        @(posedge clk);
        #1;
        check_outputs();
        cmd_valid = valid;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        clear_log = clr;
        rd = valid && (op == op_read);
        if (valid && op == op_write) begin
            model_mem[addr] = {^data, data};
        end
        if (valid && op == op_inject) begin
            model_mem[addr] = {~^data, data};  // bad parity on purpose.
        end
        exp_valid_q.push_back(rd);
        exp_addr_q.push_back(addr);
        if (rd) begin
            exp_data_q.push_back(model_mem[addr][6:0]);
            exp_err_q.push_back(^model_mem[addr]);
        end else begin
            exp_data_q.push_back('0);
            exp_err_q.push_back(1'b0);
        end
        if (clr) begin
            model_count       = '0;  // clear beats a same cycle error.
            model_first_valid = 1'b0;
        end
    endtask

    // all eight lanes of one word plus a planted fault in lane 3.
    task automatic lane_test(input byte_addr_t base);
        for (int lane = 0; lane < 8; lane++) begin
            rng = xorshift32(rng);
            issue_cmd(1'b1, op_write, base + byte_addr_t'(lane), rng[6:0], 1'b0);
        end
        for (int lane = 0; lane < 8; lane++) begin
            issue_cmd(1'b1, op_read, base + byte_addr_t'(lane), '0, 1'b0);
        end
        rng = xorshift32(rng);
        issue_cmd(1'b1, op_inject, base + byte_addr_t'(3), rng[6:0], 1'b0);
        for (int lane = 0; lane < 8; lane++) begin
            issue_cmd(1'b1, op_read, base + byte_addr_t'(lane), '0, 1'b0);
        end
        rng = xorshift32(rng);
        issue_cmd(1'b1, op_write, base + byte_addr_t'(3), rng[6:0], 1'b0);
        issue_cmd(1'b1, op_read, base + byte_addr_t'(3), '0, 1'b0);
    endtask

    // repeated reads of one faulty byte push the error counter past its maximum.
    task automatic saturation_test(input byte_addr_t addr);
        rng = xorshift32(rng);
        issue_cmd(1'b1, op_inject, addr, rng[6:0], 1'b0);
        for (int i = 0; i < n_saturate; i++) begin
            issue_cmd(1'b1, op_read, addr, '0, 1'b0);
        end
    endtask

    initial begin : stimulus
        logic       valid;
        logic       clr;
        pm_op_e     op;
        byte_addr_t addr;
        byte_addr_t win_base;
        rst_n             = 1'b0;
        cmd_valid         = 1'b0;
        cmd_op            = op_nop;
        cmd_addr          = '0;
        cmd_data          = '0;
        clear_log         = 1'b0;
        model_count       = '0;
        model_first_valid = 1'b0;
        model_first_addr  = '0;
        win_base          = '0;
        rng               = 32'he207b6bd;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int w = 0; w < 4; w++) begin
            rng = xorshift32(rng);
            lane_test(byte_addr_t'(rng) & ~byte_addr_t'(7));
        end

        rng = xorshift32(rng);
        saturation_test(byte_addr_t'(rng));

        for (int i = 0; i < n_random; i++) begin
            rng = xorshift32(rng);
            if (i % 64 == 0) begin
                win_base = byte_addr_t'(rng >> 12);  // small window so addresses repeat.
            end
            addr  = win_base + byte_addr_t'(rng[3:0]);
            op    = pm_op_e'(rng[5:4]);
            valid = (rng[10:8] != 3'd0);
            clr   = (rng[20:16] == 5'd0);
            if (op == op_read && !model_mem.exists(addr)) begin
                op = op_write;
            end
            issue_cmd(valid, op, addr, rng[27:21], clr);
        end

        repeat (4) issue_cmd(1'b0, op_nop, '0, '0, 1'b0);  // drain.
        $display("Test OK");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/parity_mem_pkg.sv
hdl/mem_if.sv
hdl/access_ctrl.sv
hdl/lane_codec.sv
hdl/word_array.sv
hdl/error_log.sv
hdl/parity_mem_top.sv
tb/parity_mem_chk.sv
tb/parity_mem_tb.sv

//--- Makefile
TOP = parity_mem_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o sim

run: build
	./obj_dir/sim

clean:
	rm -rf obj_dir
